//--- files.f
rtl/core_pkg.sv
rtl/instr_decode.sv
rtl/alu_exec.sv
rtl/retire_unit.sv
rtl/instr_tracker.sv
rtl/core_top.sv
tests/core_checker.sv
tests/tb_core_top.sv

//--- Bender.yml
package:
  name: core_tracker

sources:
  - rtl/core_pkg.sv
  - rtl/instr_decode.sv
  - rtl/alu_exec.sv
  - rtl/retire_unit.sv
  - rtl/instr_tracker.sv
  - rtl/core_top.sv
  - target: test
    files:
      - tests/core_checker.sv
      - tests/tb_core_top.sv

//--- tests/tb_core_top.sv
module tb_core_top;

    import core_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    t_instr      instr;
    logic        retire_valid;
    t_retire_rec retire;
    logic        trace_valid;
    t_trace_rec  trace;
    t_cycle      cycle;
    int          outstanding;
    int          error_count;
    logic [31:0] lfsr;
    logic        timed_out;

    core_top #(
        .TRACK_SLOTS (4)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire       (retire),
        .trace_valid  (trace_valid),
        .trace        (trace)
    );

    core_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire       (retire),
        .trace_valid  (trace_valid),
        .trace        (trace),
        .cycle        (cycle),
        .outstanding  (outstanding),
        .error_count  (error_count)
    );

    always #2 clk = ~clk;

    // same counting rule as the tracker in the DUT.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 16'd1;
        end
    end

    function automatic logic [15:0] encode(logic [3:0] op, logic [2:0] rd,
                                           logic [2:0] rs1, logic [5:0] operand);
        return {op, rd, rs1, operand};
    endfunction

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic send_instr(logic [15:0] word);
        instr_valid <= 1'b1;
        instr <= word;
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic idle(int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (outstanding != 0 && waited < 64) begin
            @(posedge clk);
            waited++;
        end
        if (outstanding != 0) begin
            timed_out = 1'b1;
            $display("timeout: %0d instructions never produced a trace record", outstanding);
        end
    endtask

    task automatic run_tests();
        logic [15:0] opbits;
        logic [15:0] rest;
        logic [15:0] gap;
        logic [2:0]  prev;
        logic [2:0]  dst;

        u_checker.start_test("reset");
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        idle(12);
        u_checker.end_test();

        u_checker.start_test("directed_alu");
        send_instr(encode(OP_ADDI, 3'd1, 3'd0, 6'd5));
        send_instr(encode(OP_ADDI, 3'd2, 3'd0, 6'h3d)); // -3.
        send_instr(encode(OP_ADD, 3'd3, 3'd1, {3'd2, 3'd0}));
        send_instr(encode(OP_SUB, 3'd4, 3'd1, {3'd2, 3'd0}));
        idle(2);
        send_instr(encode(OP_AND, 3'd5, 3'd1, {3'd2, 3'd0}));
        send_instr(encode(OP_OR, 3'd6, 3'd1, {3'd2, 3'd0}));
        send_instr(encode(OP_XOR, 3'd7, 3'd1, {3'd2, 3'd0}));
        send_instr(encode(OP_SHL, 3'd3, 3'd1, 6'd9));
        send_instr(encode(OP_ADDI, 3'd0, 3'd1, 6'd7)); // dropped write to r0.
        send_instr(encode(OP_NOP, 3'd4, 3'd1, {3'd2, 3'd0}));
        send_instr(encode(4'hb, 3'd5, 3'd1, {3'd2, 3'd0}));
        send_instr(encode(OP_ADD, 3'd6, 3'd0, {3'd1, 3'd0}));
        wait_drain();
        if (timed_out) return;
        u_checker.end_test();

        u_checker.start_test("dependency_chain");
        prev = 3'd1;
        for (int i = 0; i < 24; i++) begin
            dst = 3'(i % 7) + 3'd1;
            send_instr(encode(4'(i % 7), dst, prev, {prev, 3'(i)}));
            prev = dst;
        end
        wait_drain();
        if (timed_out) return;
        u_checker.end_test();

        u_checker.start_test("random_stream");
        for (int i = 0; i < 300; i++) begin
            take_bits(3, opbits);
            take_bits(12, rest);
            send_instr({1'b0, opbits[2:0], rest[11:0]});
            take_bits(2, gap);
            if (gap[1:0] == 2'd3) begin
                idle(3);
            end
        end
        wait_drain();
        if (timed_out) return;
        u_checker.end_test();

        u_checker.start_test("trace_stamps");
        for (int i = 0; i < 6; i++) begin
            send_instr(encode(OP_ADDI, 3'(i + 1), 3'(i), 6'(i)));
            idle(i);
        end
        wait_drain();
        if (timed_out) return;
        u_checker.end_test();
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        lfsr = 32'hea52d9bb;
        timed_out = 1'b0;
        run_tests();
        u_checker.report();
        if (timed_out || error_count != 0) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule

//--- tests/core_checker.sv
module core_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    input  core_pkg::t_instr      instr,
    input  logic                  retire_valid,
    input  core_pkg::t_retire_rec retire,
    input  logic                  trace_valid,
    input  core_pkg::t_trace_rec  trace,
    input  core_pkg::t_cycle      cycle,
    output int                    outstanding,
    output int                    error_count
);

    import core_pkg::*;

    t_data       model [NUM_REGS];
    t_retire_rec exp_retire [$];
    t_trace_rec  exp_trace [$];
    t_retire_rec sent_rec;
    t_trace_rec  sent_trace;
    t_retire_rec want_rec;
    t_trace_rec  want_trace;
    t_retire_rec last_retire;
    logic        last_retire_valid;
    t_seq_id     next_seq;
    int          sent_count;
    int          traced_count;
    int          check_count;
    int          test_count;
    int          base_checks;
    int          base_errors;
    string       cur_test;

    assign outstanding = sent_count - traced_count;

    // expected retire record, from the reference register model.
    function automatic t_retire_rec expect_retire(t_instr ins, t_seq_id seq);
        t_data       a;
        t_data       b;
        t_data       imm;
        t_retire_rec r;
        a = model[ins.rs1];
        b = model[ins.operand[5:3]];
        imm = {{10{ins.operand[5]}}, ins.operand};
        r.seq = seq;
        r.rd = ins.rd;
        case (ins.opcode)
            OP_ADD:  r.value = a + b;
            OP_SUB:  r.value = a - b;
            OP_AND:  r.value = a & b;
            OP_OR:   r.value = a | b;
            OP_XOR:  r.value = a ^ b;
            OP_SHL:  r.value = a << ins.operand[3:0];
            OP_ADDI: r.value = a + imm;
            default: r.value = '0; // nop and undefined codes.
        endcase
        r.we = (ins.opcode < OP_NOP) && (ins.rd != 3'd0);
        return r;
    endfunction

    task automatic compare_value(string what, logic [127:0] exp, logic [127:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("[FAIL] %s: %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic note_error(string msg);
        error_count++;
        $display("error in %s: %s", cur_test, msg);
    endtask

    task automatic start_test(string name);
        cur_test = name;
        base_checks = check_count;
        base_errors = error_count;
        test_count++;
    endtask

    task automatic end_test();
        $display("test %s: %0d checks, %0d errors", cur_test,
                 check_count - base_checks, error_count - base_errors);
    endtask

    task automatic report();
        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
    endtask

    // expected records are queued as each instruction is accepted.
    always @(negedge clk) begin
        if (!rst_n) begin
            next_seq = '0;
            sent_count = 0;
            for (int i = 0; i < NUM_REGS; i++) begin
                model[i] = '0;
            end
        end else if (instr_valid) begin
            sent_rec = expect_retire(instr, next_seq);
            if (sent_rec.we) begin
                model[sent_rec.rd] = sent_rec.value;
            end
            sent_trace.seq = next_seq;
            sent_trace.fetch_cyc = cycle;
            sent_trace.decode_cyc = cycle + 16'd1;
            sent_trace.exec_cyc = cycle + 16'd2;
            sent_trace.retire_cyc = cycle + 16'd3;
            sent_trace.rd = sent_rec.rd;
            sent_trace.value = sent_rec.value;
            exp_retire.push_back(sent_rec);
            exp_trace.push_back(sent_trace);
            next_seq++;
            sent_count++;
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            traced_count = 0;
            last_retire_valid = 1'b0;
            check_count++;
            if (retire_valid !== 1'b0 || trace_valid !== 1'b0) begin
                note_error("a valid output is high while reset is asserted");
            end
        end else begin
            if (retire_valid && exp_retire.size() == 0) begin
                note_error("retire strobe with no instruction outstanding");
            end else if (retire_valid) begin
                want_rec = exp_retire.pop_front();
                compare_value("retire record", want_rec, retire);
            end
            if (trace_valid && exp_trace.size() == 0) begin
                note_error("trace strobe with no instruction outstanding");
            end else if (trace_valid) begin
                want_trace = exp_trace.pop_front();
                traced_count++;
                compare_value("trace record", want_trace, trace);
                if (!last_retire_valid) begin
                    note_error("trace record without a retire one cycle earlier");
                end else begin
                    compare_value("trace against retire",
                                  {last_retire.seq, last_retire.rd, last_retire.value},
                                  {trace.seq, trace.rd, trace.value});
                end
            end
            last_retire_valid = retire_valid;
            last_retire = retire;
        end
    end

endmodule

//--- rtl/core_top.sv
module core_top #(
    parameter int TRACK_SLOTS = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    input  core_pkg::t_instr      instr,
    output logic                  retire_valid,
    output core_pkg::t_retire_rec retire,
    output logic                  trace_valid,
    output core_pkg::t_trace_rec  trace
);

    import core_pkg::*;

    t_seq_id   fetch_seq;
    logic      uop_valid;
    t_uop      uop;
    logic      ex_valid;
    t_exec_res ex_res;

    instr_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .fetch_seq   (fetch_seq),
        .uop_valid   (uop_valid),
        .uop         (uop)
    );

    alu_exec u_exec (
        .clk       (clk),
        .rst_n     (rst_n),
        .uop_valid (uop_valid),
        .uop       (uop),
        .ex_valid  (ex_valid),
        .ex_res    (ex_res)
    );

    retire_unit u_retire (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_res       (ex_res),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    instr_tracker #(
        .TRACK_SLOTS (TRACK_SLOTS)
    ) u_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .fetch_seq    (fetch_seq),
        .uop_valid    (uop_valid),
        .uop_seq      (uop.seq),
        .ex_valid     (ex_valid),
        .ex_seq       (ex_res.seq),
        .retire_valid (retire_valid),
        .retire       (retire),
        .trace_valid  (trace_valid),
        .trace        (trace)
    );

endmodule

//--- rtl/instr_tracker.sv
module instr_tracker #(
    parameter int TRACK_SLOTS = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    output core_pkg::t_seq_id     fetch_seq,
    input  logic                  uop_valid,
    input  core_pkg::t_seq_id     uop_seq,
    input  logic                  ex_valid,
    input  core_pkg::t_seq_id     ex_seq,
    input  logic                  retire_valid,
    input  core_pkg::t_retire_rec retire,
    output logic                  trace_valid,
    output core_pkg::t_trace_rec  trace
);

    import core_pkg::*;

    // up to four ids are in flight, so TRACK_SLOTS must be a power of two >= 4.
    localparam int IDX_W = $clog2(TRACK_SLOTS);

    typedef logic [IDX_W-1:0] t_slot;

    t_cycle  cycle_cnt;
    t_seq_id next_seq;

    t_cycle fetch_tab  [TRACK_SLOTS];
    t_cycle decode_tab [TRACK_SLOTS];
    t_cycle exec_tab   [TRACK_SLOTS];

    t_slot fetch_slot;
    t_slot decode_slot;
    t_slot exec_slot;
    t_slot retire_slot;

    t_trace_rec trace_d;

    assign fetch_seq = next_seq;

    assign fetch_slot = next_seq[IDX_W-1:0];
    assign decode_slot = uop_seq[IDX_W-1:0];
    assign exec_slot = ex_seq[IDX_W-1:0];
    assign retire_slot = retire.seq[IDX_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
            next_seq <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1; // wraps.
            if (instr_valid) begin
                next_seq <= next_seq + 1'b1;
            end
        end
    end

    // stamp table, one write port per stage.
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            fetch_tab[fetch_slot] <= cycle_cnt;
        end
        if (uop_valid) begin
            decode_tab[decode_slot] <= cycle_cnt;
        end
        if (ex_valid) begin
            exec_tab[exec_slot] <= cycle_cnt;
        end
    end

    always_comb begin
        trace_d.seq = retire.seq;
        trace_d.fetch_cyc = fetch_tab[retire_slot];
        trace_d.decode_cyc = decode_tab[retire_slot];
        trace_d.exec_cyc = exec_tab[retire_slot];
        trace_d.retire_cyc = cycle_cnt;
        trace_d.rd = retire.rd;
        trace_d.value = retire.value;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trace_valid <= 1'b0;
        end else begin
            trace_valid <= retire_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (retire_valid) begin
            trace <= trace_d;
        end
    end

endmodule

//--- rtl/retire_unit.sv
module retire_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ex_valid,
    input  core_pkg::t_exec_res   ex_res,
    output logic                  retire_valid,
    output core_pkg::t_retire_rec retire
);

    import core_pkg::*;

    t_retire_rec retire_d;

    // in-order pipe, so results commit in arrival order.
    always_comb begin
        retire_d.seq = ex_res.seq;
        retire_d.rd = ex_res.rd;
        retire_d.value = ex_res.value;
        retire_d.we = ex_res.we;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            retire <= retire_d; // holds last record between strobes.
        end
    end

endmodule

//--- rtl/alu_exec.sv
module alu_exec (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                uop_valid,
    input  core_pkg::t_uop      uop,
    output logic                ex_valid,
    output core_pkg::t_exec_res ex_res
);

    import core_pkg::*;

    t_data regs [NUM_REGS];
    t_data src_a;
    t_data src_b;
    t_data result;

    // r0 is never written, so it always reads as its reset value of zero.
    assign src_a = regs[uop.rs1];
    assign src_b = regs[uop.rs2];

    always_comb begin
        case (uop.opcode)
            OP_ADD: begin
                result = src_a + src_b;
            end
            OP_SUB: begin
                result = src_a - src_b;
            end
            OP_AND: begin
                result = src_a & src_b;
            end
            OP_OR: begin
                result = src_a | src_b;
            end
            OP_XOR: begin
                result = src_a ^ src_b;
            end
            OP_SHL: begin
                result = src_a << uop.imm[3:0]; // shift amount from instr.
            end
            OP_ADDI: begin
                result = src_a + uop.imm;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // writeback on the edge that raises ex_valid, no bypass needed.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            ex_valid <= uop_valid;
            if (uop_valid && uop.we) begin
                regs[uop.rd] <= result;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (uop_valid) begin
            ex_res.seq <= uop.seq;
            ex_res.rd <= uop.rd;
            ex_res.value <= result;
            ex_res.we <= uop.we;
        end
    end

endmodule

//--- rtl/instr_decode.sv
module instr_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  core_pkg::t_instr  instr,
    input  core_pkg::t_seq_id fetch_seq,
    output logic              uop_valid,
    output core_pkg::t_uop    uop
);

    import core_pkg::*;

    t_uop    uop_d;
    t_opcode op;

    always_comb begin
        op = OP_NOP;
        uop_d = '0;
        uop_d.seq = fetch_seq;
        uop_d.rd = instr.rd;
        uop_d.rs1 = instr.rs1;
        uop_d.imm = {{10{instr.operand[5]}}, instr.operand}; // simm6.

        case (instr.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                op = instr.opcode;
                uop_d.rs2 = instr.operand[5:3]; // register form.
            end
            OP_SHL, OP_ADDI: begin
                op = instr.opcode; // immediate form, rs2 unused.
            end
            default: begin
                op = OP_NOP;
            end
        endcase

        uop_d.opcode = op;
        // r0 is hardwired, so nothing is written back for it.
        uop_d.we = (op != OP_NOP) && (instr.rd != '0);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uop_valid <= 1'b0;
        end else begin
            uop_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            uop <= uop_d;
        end
    end

endmodule

//--- rtl/core_pkg.sv
package core_pkg;

    localparam int NUM_REGS = 8;

    typedef logic [15:0] t_data;
    typedef logic [2:0]  t_reg_idx;
    typedef logic [7:0]  t_seq_id;
    typedef logic [15:0] t_cycle;
    typedef logic [5:0]  t_operand;

    // codes 4'h8 to 4'hf are treated as OP_NOP by decode.
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_SHL  = 4'h5,
        OP_ADDI = 4'h6,
        OP_NOP  = 4'h7
    } t_opcode;

    // operand is {rs2, 3'bx} for register forms, simm6 for OP_ADDI,
    // and the shift amount in bits [3:0] for OP_SHL.
    typedef struct packed {
        t_opcode  opcode;
        t_reg_idx rd;
        t_reg_idx rs1;
        t_operand operand;
    } t_instr;

    typedef struct packed {
        t_seq_id  seq;
        t_opcode  opcode;
        t_reg_idx rd;
        t_reg_idx rs1;
        t_reg_idx rs2;
        t_data    imm;
        logic     we;
    } t_uop;

    typedef struct packed {
        t_seq_id  seq;
        t_reg_idx rd;
        t_data    value;
        logic     we;
    } t_exec_res;

    typedef t_exec_res t_retire_rec;

    typedef struct packed {
        t_seq_id  seq;
        t_cycle   fetch_cyc;
        t_cycle   decode_cyc;
        t_cycle   exec_cyc;
        t_cycle   retire_cyc;
        t_reg_idx rd;
        t_data    value;
    } t_trace_rec;

endpackage
